//--- stash_params.svh
`ifndef STASH_PARAMS_SVH
`define STASH_PARAMS_SVH

// --------------------------------------------------
// Stash sizing
// --------------------------------------------------

// Key width in bits
`define STASH_KEY_W 8

// Value width in bits
`define STASH_VAL_W 8

// Number of table slots
// Index and fill widths are derived from this in the package
`define STASH_SIZE 8

`endif

//--- stash_pkg.sv
package stash_pkg;

`include "stash_params.svh"

    // --------------------------------------------------
    // Entry payload types
    // --------------------------------------------------
    typedef logic [`STASH_KEY_W-1:0] key_t;
    typedef logic [`STASH_VAL_W-1:0] value_t;

    // Slot index, 0 .. SIZE-1
    typedef logic [$clog2(`STASH_SIZE)-1:0] idx_t;

    // Occupancy, 0 .. SIZE inclusive
    typedef logic [$clog2(`STASH_SIZE+1)-1:0] fill_t;

    // --------------------------------------------------
    // Opcodes and FSM states
    // --------------------------------------------------

    // Write port opcode
    typedef enum logic {
        WR_INSERT = 1'b0,
        WR_DELETE = 1'b1
    } wr_op_t;

    // Control FSM
    typedef enum logic {
        CTRL_CLEAR = 1'b0,
        CTRL_READY = 1'b1
    } ctrl_state_t;

endpackage : stash_pkg

//--- stash_ctrl.sv
`timescale 1ns/1ps

module stash_ctrl (
    input  logic clk,
    input  logic srst,

    // Table init request
    input  logic init,

    // Raw request strobes from the application
    input  logic wr_req,
    input  logic rd_req,

    output logic ready,
    output logic clear,
    output logic wr_go,
    output logic rd_go
);

    import stash_pkg::*;

    // --------------------------------------------------
    // Signals
    // --------------------------------------------------
    ctrl_state_t state;

    // --------------------------------------------------
    // Init / reset sequencing
    // --------------------------------------------------
    // Reset parks the FSM in CTRL_CLEAR with clear low.
    // First cycle out of reset raises clear, the next one
    // moves to CTRL_READY, so ready shows up two cycles
    // after srst drops.
    // An init pulse goes straight to CTRL_CLEAR with clear
    // already high, so ready is back one cycle later.
    always_ff @(posedge clk) begin
        if (srst) begin
            state <= CTRL_CLEAR;
            clear <= 1'b0;
        end else if (init) begin
            state <= CTRL_CLEAR;
            clear <= 1'b1;
        end else begin
            case (state)
                CTRL_CLEAR: begin
                    // Clear pulse lasts exactly one cycle
                    clear <= !clear;
                    if (clear) begin
                        state <= CTRL_READY;
                    end
                end
                CTRL_READY: begin
                    clear <= 1'b0;
                end
                default: begin
                    state <= CTRL_CLEAR;
                    clear <= 1'b0;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // Ready level and accepted requests
    // --------------------------------------------------
    // Ready doubles as init_done
    assign ready = (state == CTRL_READY);

    // Requests while not ready are dropped, no ack follows
    assign wr_go = wr_req && ready;
    assign rd_go = rd_req && ready;

endmodule : stash_ctrl

//--- stash_table.sv
`timescale 1ns/1ps

`include "stash_params.svh"

module stash_table (
    input  logic              clk,
    input  logic              srst,

    // Clear pulse from control
    input  logic              clear,

    // Accepted write
    input  logic              wr_go,
    input  stash_pkg::wr_op_t wr_op,
    input  stash_pkg::key_t   wr_key,
    input  stash_pkg::value_t wr_value,

    // Accepted read
    input  logic              rd_go,
    input  logic              rd_next,
    input  stash_pkg::key_t   rd_key,

    // Write response
    output logic              wr_ack,
    output logic              wr_error,

    // Read response
    output logic              rd_ack,
    output logic              rd_valid,
    output stash_pkg::value_t rd_value,
    output stash_pkg::key_t   rd_next_key,

    // Status events
    output stash_pkg::fill_t  fill,
    output logic              evt_activate,
    output logic              evt_deactivate
);

    import stash_pkg::*;

    // --------------------------------------------------
    // Signals
    // --------------------------------------------------
    // Entry storage, no reset
    key_t   key_mem [`STASH_SIZE];
    value_t val_mem [`STASH_SIZE];

    // Slot occupancy
    logic [`STASH_SIZE-1:0] valid;

    logic table_full;

    // Write side
    logic wr_match;
    idx_t wr_match_idx;
    idx_t insert_idx;
    logic wr_en;
    idx_t wr_idx;
    logic del_en;

    // Read side
    logic rd_match;
    idx_t rd_match_idx;
    idx_t iter_idx;

    // --------------------------------------------------
    // Occupancy
    // --------------------------------------------------
    // Population count of the valid vector
    always_comb begin
        fill = '0;
        for (int i = 0; i < `STASH_SIZE; i++) begin
            if (valid[i]) begin
                fill = fill + fill_t'(1);
            end
        end
    end

    assign table_full = (fill == fill_t'(`STASH_SIZE));

    // --------------------------------------------------
    // Write match and insert slot
    // --------------------------------------------------
    // Only valid slots may match
    always_comb begin
        wr_match     = 1'b0;
        wr_match_idx = '0;
        for (int i = 0; i < `STASH_SIZE; i++) begin
            if (valid[i] && (key_mem[i] == wr_key)) begin
                wr_match     = 1'b1;
                wr_match_idx = idx_t'(i);
            end
        end
    end

    // Highest-numbered free slot wins
    always_comb begin
        insert_idx = '0;
        for (int i = 0; i < `STASH_SIZE; i++) begin
            if (!valid[i]) begin
                insert_idx = idx_t'(i);
            end
        end
    end

    // Update in place on a hit, else take a free slot if any
    assign wr_en  = wr_go && (wr_op == WR_INSERT) && (wr_match || !table_full);
    assign wr_idx = wr_match ? wr_match_idx : insert_idx;

    // Delete only acts on a hit
    assign del_en = wr_go && (wr_op == WR_DELETE) && wr_match;

    // New entry vs. removed entry
    assign evt_activate   = wr_en && !wr_match;
    assign evt_deactivate = del_en;

    // --------------------------------------------------
    // Storage update
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst || clear) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[wr_idx] <= 1'b1;
        end else if (del_en) begin
            valid[wr_match_idx] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            key_mem[wr_idx] <= wr_key;
            val_mem[wr_idx] <= wr_value;
        end
    end

    // Write response, one cycle after accept
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ack   <= 1'b0;
            wr_error <= 1'b0;
        end else begin
            wr_ack   <= wr_go;
            // Insert of a new key into a full table
            wr_error <= wr_go && (wr_op == WR_INSERT) && !wr_match && table_full;
        end
    end

    // --------------------------------------------------
    // Read side
    // --------------------------------------------------
    always_comb begin
        rd_match     = 1'b0;
        rd_match_idx = '0;
        for (int i = 0; i < `STASH_SIZE; i++) begin
            if (valid[i] && (key_mem[i] == rd_key)) begin
                rd_match     = 1'b1;
                rd_match_idx = idx_t'(i);
            end
        end
    end

    // Iterator walks 0..SIZE-1 and wraps, srst only
    always_ff @(posedge clk) begin
        if (srst) begin
            iter_idx <= '0;
        end else if (rd_go && rd_next) begin
            if (iter_idx == idx_t'(`STASH_SIZE - 1)) begin
                iter_idx <= '0;
            end else begin
                iter_idx <= iter_idx + idx_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            rd_ack <= 1'b0;
        end else begin
            rd_ack <= rd_go;
        end
    end

    // Read data sees contents from before a same-cycle write
    always_ff @(posedge clk) begin
        if (rd_go) begin
            if (rd_next) begin
                // Slot dump, valid or not
                rd_valid    <= valid[iter_idx];
                rd_value    <= val_mem[iter_idx];
                rd_next_key <= key_mem[iter_idx];
            end else begin
                rd_valid    <= rd_match;
                rd_value    <= rd_match ? val_mem[rd_match_idx] : '0;
                rd_next_key <= '0;
            end
        end
    end

endmodule : stash_table

//--- stash_status.sv
`timescale 1ns/1ps

`include "stash_params.svh"

module stash_status (
    input  logic             clk,
    input  logic             srst,
    input  logic             clear,

    // From the table
    input  stash_pkg::fill_t fill,
    input  logic             evt_activate,
    input  logic             evt_deactivate,

    output logic             full,
    output stash_pkg::fill_t peak_fill,
    output logic [15:0]      act_count,
    output logic [15:0]      deact_count
);

    import stash_pkg::*;

    // --------------------------------------------------
    // Full flag and high-water mark
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst || clear) begin
            full <= 1'b0;
        end else begin
            full <= (fill == fill_t'(`STASH_SIZE));
        end
    end

    // Peak restarts on init
    always_ff @(posedge clk) begin
        if (srst || clear) begin
            peak_fill <= '0;
        end else if (fill > peak_fill) begin
            peak_fill <= fill;
        end
    end

    // --------------------------------------------------
    // Event counters
    // --------------------------------------------------
    // Saturating, survive init
    always_ff @(posedge clk) begin
        if (srst) begin
            act_count   <= '0;
            deact_count <= '0;
        end else begin
            if (evt_activate && (act_count != '1)) begin
                act_count <= act_count + 16'd1;
            end
            if (evt_deactivate && (deact_count != '1)) begin
                deact_count <= deact_count + 16'd1;
            end
        end
    end

endmodule : stash_status

//--- stash_top.sv
`timescale 1ns/1ps

module stash_top (
    input  logic              clk,
    input  logic              srst,

    input  logic              init,

    // Write port
    input  logic              wr_req,
    input  stash_pkg::wr_op_t wr_op,
    input  stash_pkg::key_t   wr_key,
    input  stash_pkg::value_t wr_value,
    output logic              ready,
    output logic              wr_ack,
    output logic              wr_error,

    // Read port
    input  logic              rd_req,
    input  logic              rd_next,
    input  stash_pkg::key_t   rd_key,
    output logic              rd_ack,
    output logic              rd_valid,
    output stash_pkg::value_t rd_value,
    output stash_pkg::key_t   rd_next_key,

    // Status
    output stash_pkg::fill_t  fill,
    output logic              full,
    output stash_pkg::fill_t  peak_fill,
    output logic [15:0]       act_count,
    output logic [15:0]       deact_count
);

    // --------------------------------------------------
    // Internal links
    // --------------------------------------------------
    logic clear;
    logic wr_go;
    logic rd_go;
    logic evt_activate;
    logic evt_deactivate;

    // Init sequencing and request gating
    stash_ctrl u_ctrl (
        .clk    (clk),
        .srst   (srst),
        .init   (init),
        .wr_req (wr_req),
        .rd_req (rd_req),
        .ready  (ready),
        .clear  (clear),
        .wr_go  (wr_go),
        .rd_go  (rd_go)
    );

    // Associative entry array
    stash_table u_table (
        .clk            (clk),
        .srst           (srst),
        .clear          (clear),
        .wr_go          (wr_go),
        .wr_op          (wr_op),
        .wr_key         (wr_key),
        .wr_value       (wr_value),
        .rd_go          (rd_go),
        .rd_next        (rd_next),
        .rd_key         (rd_key),
        .wr_ack         (wr_ack),
        .wr_error       (wr_error),
        .rd_ack         (rd_ack),
        .rd_valid       (rd_valid),
        .rd_value       (rd_value),
        .rd_next_key    (rd_next_key),
        .fill           (fill),
        .evt_activate   (evt_activate),
        .evt_deactivate (evt_deactivate)
    );

    // Flags and counters
    stash_status u_status (
        .clk            (clk),
        .srst           (srst),
        .clear          (clear),
        .fill           (fill),
        .evt_activate   (evt_activate),
        .evt_deactivate (evt_deactivate),
        .full           (full),
        .peak_fill      (peak_fill),
        .act_count      (act_count),
        .deact_count    (deact_count)
    );

endmodule : stash_top

//--- stash_asserts.sv
`timescale 1ns/1ps

`include "stash_params.svh"

module stash_asserts (
    input logic             clk,
    input logic             srst,
    input logic             init,
    input logic             wr_req,
    input logic             rd_req,
    input logic             ready,
    input logic             wr_ack,
    input logic             wr_error,
    input logic             rd_ack,
    input stash_pkg::fill_t fill
);

    import stash_pkg::*;

    // --------------------------------------------------
    // Request and ack pairing
    // --------------------------------------------------
    wr_ack_after_accept: assert property (@(posedge clk) disable iff (srst)
        wr_ack == $past(wr_req && ready))
    else $error("wr_ack does not match an accepted write one cycle earlier");

    rd_ack_after_accept: assert property (@(posedge clk) disable iff (srst)
        rd_ack == $past(rd_req && ready))
    else $error("rd_ack does not match an accepted read one cycle earlier");

    // Error is a qualifier of the write ack
    wr_error_with_ack: assert property (@(posedge clk) disable iff (srst)
        wr_error |-> wr_ack)
    else $error("wr_error raised without wr_ack");

    // --------------------------------------------------
    // Occupancy and init sequencing
    // --------------------------------------------------
    // At most one new entry per accepted write
    fill_in_range: assert property (@(posedge clk) disable iff (srst)
        (fill <= fill_t'(`STASH_SIZE)) && (fill <= $past(fill) + fill_t'(1)))
    else $error("fill exceeds the table size or grew by more than one slot");

    ready_drops_on_init: assert property (@(posedge clk) disable iff (srst)
        init |=> !ready)
    else $error("ready still high the cycle after init");

endmodule : stash_asserts

bind stash_top stash_asserts u_asserts (
    .clk      (clk),
    .srst     (srst),
    .init     (init),
    .wr_req   (wr_req),
    .rd_req   (rd_req),
    .ready    (ready),
    .wr_ack   (wr_ack),
    .wr_error (wr_error),
    .rd_ack   (rd_ack),
    .fill     (fill)
);

//--- stash_tb.sv
`timescale 1ns/1ps

`include "stash_params.svh"

module stash_tb;

    import stash_pkg::*;

    localparam int MAX_LINES = 64;
    localparam int TIMEOUT   = 20;

    // --------------------------------------------------
    // DUT signals
    // --------------------------------------------------
    logic        clk = 1'b0;
    logic        srst;
    logic        init;
    logic        wr_req;
    wr_op_t      wr_op;
    key_t        wr_key;
    value_t      wr_value;
    logic        rd_req;
    logic        rd_next;
    key_t        rd_key;
    logic        ready;
    logic        wr_ack;
    logic        wr_error;
    logic        rd_ack;
    logic        rd_valid;
    value_t      rd_value;
    key_t        rd_next_key;
    fill_t       fill;
    logic        full;
    fill_t       peak_fill;
    logic [15:0] act_count;
    logic [15:0] deact_count;

    // One word per command with op, key, value, flag nibble and expected value
    logic [31:0] cmds [MAX_LINES];

    // Reference model of the slots
    key_t                   m_key [`STASH_SIZE];
    value_t                 m_val [`STASH_SIZE];
    logic [`STASH_SIZE-1:0] m_valid = '0;
    idx_t                   m_iter  = '0;
    int                     m_peak  = 0;
    int                     m_act   = 0;
    int                     m_deact = 0;

    int   errors    = 0;
    int   checks    = 0;
    logic timed_out = 1'b0;

    always #50 clk = ~clk;

    stash_top stash_top_inst (.*);

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0d ns: %s = %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    function automatic int model_fill();
        int n;
        n = 0;
        for (int i = 0; i < `STASH_SIZE; i++) begin
            if (m_valid[i]) n++;
        end
        return n;
    endfunction

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!ready) begin
            timed_out = 1'b1;
            $display("Timeout: ready stayed low for %0d cycles", TIMEOUT);
        end
    endtask

    task automatic wait_ack(input logic is_wr);
        int n;
        n = 0;
        while ((is_wr ? !wr_ack : !rd_ack) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (is_wr ? !wr_ack : !rd_ack) begin
            timed_out = 1'b1;
            $display("Timeout: no %s ack within %0d cycles", is_wr ? "write" : "read", TIMEOUT);
        end
    endtask

    // Insert or delete, then advance the model
    task automatic do_write(input wr_op_t op, input key_t key, input value_t val,
                            input logic exp_err);
        logic hit;
        logic free;
        idx_t hit_idx;
        idx_t free_idx;
        hit  = 1'b0;
        free = 1'b0;
        hit_idx  = '0;
        free_idx = '0;
        for (int i = 0; i < `STASH_SIZE; i++) begin
            if (m_valid[i] && m_key[i] == key) begin
                hit     = 1'b1;
                hit_idx = idx_t'(i);
            end
            // Ascending scan leaves the highest free slot
            if (!m_valid[i]) begin
                free     = 1'b1;
                free_idx = idx_t'(i);
            end
        end
        wait_ready();
        wr_req   = 1'b1;
        wr_op    = op;
        wr_key   = key;
        wr_value = val;
        @(negedge clk);
        wr_req = 1'b0;
        wait_ack(1'b1);
        check_value("wr_error", 32'(wr_error), 32'(exp_err));
        if (op == WR_INSERT && hit) begin
            m_val[hit_idx] = val;
        end else if (op == WR_INSERT && free) begin
            m_valid[free_idx] = 1'b1;
            m_key[free_idx]   = key;
            m_val[free_idx]   = val;
            m_act++;
        end else if (op == WR_DELETE && hit) begin
            m_valid[hit_idx] = 1'b0;
            m_deact++;
        end
        if (model_fill() > m_peak) m_peak = model_fill();
        check_value("fill", 32'(fill), 32'(model_fill()));
    endtask

    // Key lookup or one iterator step
    task automatic do_read(input logic next, input key_t key, input logic exp_valid,
                           input value_t exp_val);
        wait_ready();
        rd_req  = 1'b1;
        rd_next = next;
        rd_key  = key;
        @(negedge clk);
        rd_req  = 1'b0;
        rd_next = 1'b0;
        wait_ack(1'b0);
        if (next) begin
            check_value("rd_valid", 32'(rd_valid), 32'(m_valid[m_iter]));
            if (m_valid[m_iter]) begin
                check_value("rd_next_key", 32'(rd_next_key), 32'(m_key[m_iter]));
                check_value("rd_value", 32'(rd_value), 32'(m_val[m_iter]));
            end
            // Slot 7 wraps back to slot 0
            if (m_iter == idx_t'(`STASH_SIZE - 1)) m_iter = '0;
            else m_iter = m_iter + idx_t'(1);
        end else begin
            check_value("rd_valid", 32'(rd_valid), 32'(exp_valid));
            check_value("rd_value", 32'(rd_value), 32'(exp_val));
        end
    endtask

    task automatic do_init();
        wait_ready();
        init = 1'b1;
        @(negedge clk);
        init = 1'b0;
        check_value("ready", 32'(ready), 32'd0);
        m_valid = '0;
        m_peak  = 0;
        wait_ready();
    endtask

    // One idle cycle lets the registered flags settle
    task automatic do_status();
        @(negedge clk);
        check_value("fill", 32'(fill), 32'(model_fill()));
        check_value("full", 32'(full), 32'(model_fill() == `STASH_SIZE));
        check_value("peak_fill", 32'(peak_fill), 32'(m_peak));
        check_value("act_count", 32'(act_count), 32'(m_act));
        check_value("deact_count", 32'(deact_count), 32'(m_deact));
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        int          line;
        logic [31:0] cmd;
        srst     = 1'b1;
        init     = 1'b0;
        wr_req   = 1'b0;
        wr_op    = WR_INSERT;
        wr_key   = '0;
        wr_value = '0;
        rd_req   = 1'b0;
        rd_next  = 1'b0;
        rd_key   = '0;
        // End marker in every unused word
        for (int i = 0; i < MAX_LINES; i++) cmds[i] = {4'hf, 28'(i)};
        $readmemh("stash_input.txt", cmds);
        repeat (10) @(negedge clk);
        srst = 1'b0;
        wait_ready();
        line = 0;
        while (!timed_out && line < MAX_LINES && cmds[line][31:28] != 4'hf) begin
            cmd = cmds[line];
            case (cmd[31:28])
                4'h0: do_write(WR_INSERT, cmd[27:20], cmd[19:12], cmd[8]);
                4'h1: do_write(WR_DELETE, cmd[27:20], cmd[19:12], cmd[8]);
                4'h2: do_read(1'b0, cmd[27:20], cmd[8], cmd[7:0]);
                4'h3: do_read(1'b1, cmd[27:20], cmd[8], cmd[7:0]);
                4'h4: do_init();
                4'h5: do_status();
                default: begin
                    errors++;
                    $display("Unknown opcode %0h on command %0d", cmd[31:28], line);
                end
            endcase
            line++;
        end
        $display("Checks: %0d, errors: %0d, timeout: %0d", checks, errors, timed_out);
        if (timed_out || errors != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST PASSED");
        end
        $finish;
    end

endmodule : stash_tb

//--- stash_input.txt
// op_key_value_flag_expect in hex; op 0 insert, 1 delete, 2 lookup, 3 iterate, 4 init, 5 status
// flag is wr_error for writes and rd_valid for lookups; expect is rd_value; op f ends the run
0_11_a1_0_00
0_11_b2_0_00
2_11_00_1_b2
5_00_00_0_00
0_22_c2_0_00
0_33_c3_0_00
0_44_c4_0_00
0_55_c5_0_00
0_66_c6_0_00
0_77_c7_0_00
0_88_c8_0_00
0_99_d9_1_00
5_00_00_0_00
2_44_00_1_c4
1_33_00_0_00
2_33_00_0_00
1_ab_00_0_00
0_99_d9_0_00
2_99_00_1_d9
3_00_00_0_00
3_00_00_0_00
3_00_00_0_00
3_00_00_0_00
3_00_00_0_00
3_00_00_0_00
3_00_00_0_00
3_00_00_0_00
3_00_00_0_00
4_00_00_0_00
5_00_00_0_00
2_99_00_0_00
f_00_00_0_00

//--- sources.f
+incdir+.
stash_pkg.sv
stash_ctrl.sv
stash_table.sv
stash_status.sv
stash_top.sv
stash_asserts.sv
stash_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = stash_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
